// File: design/botPipePkg.sv
`default_nettype none

package botPipePkg;

    localparam int TOP_WIDTH = 32;                      // Top word and result width.
    localparam int ADDR_WIDTH = 4;                      // Bot index width.
    localparam int INIT_SPAN = 4;                       // Advances spent initializing.
    localparam int SHIFT_DEPTH = (1 << ADDR_WIDTH) - INIT_SPAN;
    localparam int OUTPUT_LATENCY = 2;                  // Retiming after last stage.

    // Manager sequencing states.
    typedef enum logic [1:0] {
        ST_IDLE,                                        // No top loaded yet.
        ST_RUNNING,
        ST_DRAINING,                                    // Waiting for empty pipeline.
        ST_INIT                                         // Initialization advances.
    } mgrState_t;

    // One accepted bot on its way into the pipeline.
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] index;
        logic [TOP_WIDTH-1:0]  top;
    } botRecord_t;

endpackage

`default_nettype wire

// File: design/shiftRegister.sv
`timescale 1ns/1ps
`default_nettype none

module shiftRegister #(
    parameter int cycles = 4,
    parameter int width = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout
);

    logic [width-1:0] stages [cycles];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cycles; i++) begin
                stages[i] <= '0;
            end
        end else if (enable) begin
            stages[0] <= din;                           // New entry at the head.
            for (int i = 1; i < cycles; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[cycles-1];                     // Oldest entry.

endmodule

`default_nettype wire

// File: design/hyperpipe.sv
`timescale 1ns/1ps
`default_nettype none

module hyperpipe #(
    parameter int cycles = 2,
    parameter int width = 1
) (
    input  logic             clk,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout
);

    logic [width-1:0] stages [cycles];

    // Free running, moves every clock regardless of stalls.
    always_ff @(posedge clk) begin
        stages[0] <= din;
        for (int i = 1; i < cycles; i++) begin
            stages[i] <= stages[i-1];
        end
    end

    assign dout = stages[cycles-1];

endmodule

`default_nettype wire

// File: design/botValidShifter.sv
`timescale 1ns/1ps
`default_nettype none

module botValidShifter (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic botValid,
    output logic resultValid,
    output logic isEmpty
);

    import botPipePkg::*;

    logic [ADDR_WIDTH-1:0] cyclesUntilEmpty;            // Advances until last bot leaves.
    logic                  exitValid;
    logic                  prevAdvance;
    logic                  resultPulse;

    assign isEmpty = (cyclesUntilEmpty == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            cyclesUntilEmpty <= '0;
        end else if (advance) begin
            if (botValid) begin
                cyclesUntilEmpty <= ADDR_WIDTH'(SHIFT_DEPTH);   // Newest bot restarts the count.
            end else if (!isEmpty) begin
                cyclesUntilEmpty <= cyclesUntilEmpty - 1'b1;
            end
        end
    end

    shiftRegister #(.cycles(SHIFT_DEPTH), .width(1)) validRegister (
        .clk    (clk),
        .rst    (rst),
        .enable (advance),
        .din    (botValid),
        .dout   (exitValid)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            prevAdvance <= 1'b0;
        end else begin
            prevAdvance <= advance;
        end
    end

    // A stalled bot sits at the exit, so only count it right after it moved there.
    assign resultPulse = exitValid & prevAdvance;

    hyperpipe #(.cycles(OUTPUT_LATENCY), .width(1)) validDelay (
        .clk  (clk),
        .din  (resultPulse),
        .dout (resultValid)
    );

endmodule

`default_nettype wire

// File: design/pipelineManager.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineManager (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             startNewTop,
    input  logic [botPipePkg::TOP_WIDTH-1:0] topIn,
    input  logic                             isBotInValid,
    input  logic                             pipelineReady,
    input  logic                             isEmpty,
    output logic                             readyForBotIn,
    output logic                             advance,
    output botPipePkg::botRecord_t           bot
);

    import botPipePkg::*;

    mgrState_t             state;
    logic [TOP_WIDTH-1:0]  pendingTop;                  // Requested top, waiting for drain.
    logic [TOP_WIDTH-1:0]  currentTop;
    logic [ADDR_WIDTH-1:0] botIndex;
    logic                  topAccepted;
    logic                  botAccepted;

    assign topAccepted = startNewTop & pipelineReady &
                         ((state == ST_IDLE) || (state == ST_RUNNING));

    assign readyForBotIn = pipelineReady & (state == ST_RUNNING) & !startNewTop;
    assign botAccepted = isBotInValid & readyForBotIn;

    // Shifters move while running or draining, never while initializing.
    assign advance = pipelineReady & !rst &
                     ((state == ST_RUNNING) || (state == ST_DRAINING));

    always_comb begin
        bot.valid = botAccepted;
        bot.index = botIndex;
        bot.top   = currentTop;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            botIndex <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (topAccepted) begin
                        state <= ST_DRAINING;
                    end
                end
                ST_RUNNING: begin
                    if (topAccepted) begin
                        state <= ST_DRAINING;
                    end
                    if (pipelineReady) begin
                        botIndex <= botIndex + 1'b1;    // Index counts advances.
                    end
                end
                ST_DRAINING: begin
                    if (isEmpty && pipelineReady) begin
                        state    <= ST_INIT;
                        botIndex <= ADDR_WIDTH'(-INIT_SPAN);    // Start below zero.
                    end
                end
                ST_INIT: begin
                    if (pipelineReady) begin
                        botIndex <= botIndex + 1'b1;
                        if (botIndex == '1) begin
                            state <= ST_RUNNING;        // Next index is zero.
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Top words carry no reset.
    always_ff @(posedge clk) begin
        if (topAccepted) begin
            pendingTop <= topIn;
        end
        if ((state == ST_DRAINING) && isEmpty && pipelineReady) begin
            currentTop <= pendingTop;                   // Old bots are all out.
        end
    end

endmodule

`default_nettype wire

// File: design/resultPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module resultPipeline (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             advance,
    input  botPipePkg::botRecord_t           bot,
    output logic [botPipePkg::TOP_WIDTH-1:0] resultData
);

    import botPipePkg::*;

    logic [2*TOP_WIDTH-1:0] doubledTop;
    logic [TOP_WIDTH-1:0]   rotatedTop;
    logic [TOP_WIDTH-1:0]   botResult;
    logic [TOP_WIDTH-1:0]   exitData;
    logic [TOP_WIDTH-1:0]   sampledData;
    logic                   prevAdvance;

    // Rotate left through a doubled copy of the top.
    always_comb begin
        doubledTop = {bot.top, bot.top} << bot.index;
        rotatedTop = doubledTop[2*TOP_WIDTH-1:TOP_WIDTH];
        if (bot.valid) begin
            botResult = rotatedTop + TOP_WIDTH'(bot.index);
        end else begin
            botResult = '0;                             // Bubbles carry zero.
        end
    end

    shiftRegister #(.cycles(SHIFT_DEPTH), .width(TOP_WIDTH)) dataRegister (
        .clk    (clk),
        .rst    (rst),
        .enable (advance),
        .din    (botResult),
        .dout   (exitData)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            prevAdvance <= 1'b0;
        end else begin
            prevAdvance <= advance;
        end
    end

    // Same qualifier as the valid path.
    assign sampledData = prevAdvance ? exitData : '0;

    hyperpipe #(.cycles(OUTPUT_LATENCY), .width(TOP_WIDTH)) dataDelay (
        .clk  (clk),
        .din  (sampledData),
        .dout (resultData)
    );

endmodule

`default_nettype wire

// File: design/botPipeTop.sv
`timescale 1ns/1ps
`default_nettype none

module botPipeTop (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             startNewTop,
    input  logic [botPipePkg::TOP_WIDTH-1:0] topIn,
    input  logic                             isBotInValid,
    input  logic                             pipelineReady,
    output logic                             readyForBotIn,
    output logic                             resultValid,
    output logic [botPipePkg::TOP_WIDTH-1:0] resultData
);

    import botPipePkg::*;

    logic       advance;                                // Shared shift enable.
    logic       isEmpty;
    botRecord_t bot;

    pipelineManager i_pipelineManager (
        .clk           (clk),
        .rst           (rst),
        .startNewTop   (startNewTop),
        .topIn         (topIn),
        .isBotInValid  (isBotInValid),
        .pipelineReady (pipelineReady),
        .isEmpty       (isEmpty),
        .readyForBotIn (readyForBotIn),
        .advance       (advance),
        .bot           (bot)
    );

    botValidShifter i_botValidShifter (
        .clk         (clk),
        .rst         (rst),
        .advance     (advance),
        .botValid    (bot.valid),
        .resultValid (resultValid),
        .isEmpty     (isEmpty)
    );

    resultPipeline i_resultPipeline (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .bot        (bot),
        .resultData (resultData)
    );

endmodule

`default_nettype wire

// File: dv/botPipeChecker.sv
`timescale 1ns/1ps
`default_nettype none

module botPipeChecker (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             startNewTop,
    input  logic                             isBotInValid,
    input  logic                             pipelineReady,
    input  logic                             readyForBotIn,
    input  logic                             resultValid,
    input  logic [botPipePkg::TOP_WIDTH-1:0] resultData
);

    import botPipePkg::*;

    logic [TOP_WIDTH-1:0] expectedQueue [$];            // Results still owed, oldest first.
    logic [TOP_WIDTH-1:0] expectedValue;
    string                testName = "none";
    int                   testErrors = 0;
    int                   testResults = 0;
    int                   acceptedBots = 0;             // Bots taken since test start or reset.
    int                   expectedBots = 0;
    int                   testsRun = 0;
    int                   testsFailed = 0;
    int                   errorCount = 0;

    // Outputs are registered, so the falling edge sees settled values.
    always @(negedge clk) begin
        if (rst) begin
            acceptedBots = 0;                           // Reset drops bots in flight.
        end else begin
            if (readyForBotIn && (!pipelineReady || startNewTop)) begin
                $display("FAIL %0t: test %s has readyForBotIn high in a stall or top request",
                         $time, testName);
                testErrors++;
                errorCount++;
            end else if (readyForBotIn && isBotInValid) begin
                acceptedBots++;
            end
            if (resultValid) begin
                testResults++;
                if (expectedQueue.size() == 0) begin
                    $display("Test %s: unexpected extra result %h at time %0t",
                             testName, resultData, $time);
                    testErrors++;
                    errorCount++;
                end else begin
                    expectedValue = expectedQueue.pop_front();
                    if (resultData !== expectedValue) begin
                        $display("FAIL %0t: test %s gave result %h, expected %h",
                                 $time, testName, resultData, expectedValue);
                        testErrors++;
                        errorCount++;
                    end
                end
            end
        end
    end

    task startTest(input string name);
        testName = name;
        testErrors = 0;
        testResults = 0;
        acceptedBots = 0;
        expectedBots = 0;
        expectedQueue.delete();
    endtask

    task pushExpected(input logic [TOP_WIDTH-1:0] value);
        expectedQueue.push_back(value);
        expectedBots++;
    endtask

    task finishTest();
        if (acceptedBots != expectedBots) begin
            $display("FAIL %0t: test %s accepted %0d bots, expected %0d",
                     $time, testName, acceptedBots, expectedBots);
            testErrors++;
            errorCount++;
        end
        if (expectedQueue.size() != 0) begin
            $display("Test %s: %0d expected results never appeared",
                     testName, expectedQueue.size());
            testErrors += expectedQueue.size();
            errorCount += expectedQueue.size();
            expectedQueue.delete();
        end
        testsRun++;
        if (testErrors == 0) begin
            $display("Test %s: passed, %0d results", testName, testResults);
        end else begin
            testsFailed++;
            $display("Test %s: failed, %0d errors", testName, testErrors);
        end
    endtask

    task printSummary();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 testsRun, testsFailed, errorCount);
    endtask

endmodule

`default_nettype wire

// File: dv/botPipe_assert.sv
`timescale 1ns/1ps
`default_nettype none

module botPipe_assert (
    input logic                   clk,
    input logic                   rst,
    input logic                   pipelineReady,
    input logic                   readyForBotIn,
    input logic                   advance,
    input logic                   isEmpty,
    input botPipePkg::mgrState_t  state,
    input botPipePkg::botRecord_t bot
);

    import botPipePkg::*;

    logic [SHIFT_DEPTH-1:0] flightBits;                 // Valid bits of bots in flight.

    always_ff @(posedge clk) begin
        if (rst) begin
            flightBits <= '0;
        end else if (advance) begin
            flightBits <= {flightBits[SHIFT_DEPTH-2:0], bot.valid};
        end
    end

    readyNeedsPipeline: assert property (@(posedge clk) disable iff (rst)
        readyForBotIn |-> pipelineReady)
        else $error("readyForBotIn high while pipelineReady low");

    noAcceptWhileBlocked: assert property (@(posedge clk) disable iff (rst)
        ((state == ST_INIT) || (state == ST_DRAINING)) |-> !bot.valid)
        else $error("Bot accepted during drain or initialization");

    emptyOnlyWhenDrained: assert property (@(posedge clk) disable iff (rst)
        $rose(isEmpty) |-> (flightBits == '0))
        else $error("isEmpty rose with a valid bot still in flight");

    quietAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> !advance)
        else $error("advance high in the first cycle after reset");

endmodule

bind pipelineManager botPipe_assert managerChecks (
    .clk           (clk),
    .rst           (rst),
    .pipelineReady (pipelineReady),
    .readyForBotIn (readyForBotIn),
    .advance       (advance),
    .isEmpty       (isEmpty),
    .state         (state),
    .bot           (bot)
);

`default_nettype wire

// File: dv/botPipeTb.sv
`timescale 1ns/1ps
`default_nettype none

module botPipeTb;

    import botPipePkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 3;
    localparam int WATCHDOG_MARGIN = 200;

    logic                 clk;
    logic                 rst;
    logic                 startNewTop;
    logic [TOP_WIDTH-1:0] topIn;
    logic                 isBotInValid;
    logic                 pipelineReady;
    logic                 readyForBotIn;
    logic                 resultValid;
    logic [TOP_WIDTH-1:0] resultData;

    int                   seed = 32'h5415e67f;
    int                   limitCycles = 0;
    bit                   vectorsOpened;

    // Parsed vector entries, kept in parallel queues.
    int                   entryKind [$];                // 0 test, 1 cycles, 2 expected.
    string                entryName [$];
    int                   entryRst [$];
    int                   entryReady [$];
    int                   entryStart [$];
    logic [TOP_WIDTH-1:0] entryTop [$];
    int                   entryValid [$];
    int                   entryCount [$];

    botPipeTop i_botPipeTop (
        .clk           (clk),
        .rst           (rst),
        .startNewTop   (startNewTop),
        .topIn         (topIn),
        .isBotInValid  (isBotInValid),
        .pipelineReady (pipelineReady),
        .readyForBotIn (readyForBotIn),
        .resultValid   (resultValid),
        .resultData    (resultData)
    );

    botPipeChecker resultChecker (
        .clk           (clk),
        .rst           (rst),
        .startNewTop   (startNewTop),
        .isBotInValid  (isBotInValid),
        .pipelineReady (pipelineReady),
        .readyForBotIn (readyForBotIn),
        .resultValid   (resultValid),
        .resultData    (resultData)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task addEntry(input int kind, input string name, input int r, input int rdy,
                  input int s, input logic [TOP_WIDTH-1:0] t, input int v, input int n);
        entryKind.push_back(kind);
        entryName.push_back(name);
        entryRst.push_back(r);
        entryReady.push_back(rdy);
        entryStart.push_back(s);
        entryTop.push_back(t);
        entryValid.push_back(v);
        entryCount.push_back(n);
    endtask

    task readVectors(output bit opened);
        int                   fd;
        int                   code;
        int                   r;
        int                   rdy;
        int                   s;
        int                   v;
        int                   n;
        int                   k;
        string                tok;
        string                rest;
        logic [TOP_WIDTH-1:0] t;
        fd = $fopen("dv/botPipeVectors.txt", "r");
        opened = (fd != 0);
        if (opened) begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.getc(0) == 8'h23) begin
                    code = $fgets(rest, fd);            // Comment line.
                end else if (tok == "T") begin
                    code = $fscanf(fd, "%s", rest);
                    addEntry(0, rest, 0, 0, 0, '0, 0, 0);
                end else if (tok == "C") begin
                    code = $fscanf(fd, "%d %d %d %h %d %d", r, rdy, s, t, v, n);
                    addEntry(1, "", r, rdy, s, t, v, n);
                    limitCycles += (rdy == 2) ? 4 * n : n;  // Random stalls stretch lines.
                end else if (tok == "E") begin
                    code = $fscanf(fd, "%d", n);
                    for (k = 0; k < n; k++) begin
                        code = $fscanf(fd, "%h", t);
                        addEntry(2, "", 0, 0, 0, t, 0, 0);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task driveInputs(input int r, input logic rdy, input int s,
                     input logic [TOP_WIDTH-1:0] t, input int v);
        @(posedge clk);
        rst           <= (r != 0);
        pipelineReady <= rdy;
        startNewTop   <= (s != 0);
        topIn         <= t;
        isBotInValid  <= (v != 0);
    endtask

    // Ready 2 inserts random stalls, so each line still gets exactly one ready cycle.
    task applyCycles(input int idx);
        int   n;
        int   randVal;
        logic readyBit;
        for (n = 0; n < entryCount[idx]; n++) begin
            if (entryReady[idx] == 2) begin
                do begin
                    randVal = $random(seed);
                    readyBit = randVal[0];
                    driveInputs(entryRst[idx], readyBit, entryStart[idx],
                                entryTop[idx], entryValid[idx]);
                end while (!readyBit);
            end else begin
                driveInputs(entryRst[idx], entryReady[idx] != 0, entryStart[idx],
                            entryTop[idx], entryValid[idx]);
            end
        end
    endtask

    initial begin
        rst           = 1'b1;
        startNewTop   = 1'b0;
        topIn         = '0;
        isBotInValid  = 1'b0;
        pipelineReady = 1'b0;
        readVectors(vectorsOpened);
        if (!vectorsOpened) begin
            $display("Could not open the vector file dv/botPipeVectors.txt");
            $display("Finished with errors");
            $finish;
        end else begin
            limitCycles += RESET_CYCLES + WATCHDOG_MARGIN;
            repeat (RESET_CYCLES) @(posedge clk);
            rst <= 1'b0;
            for (int i = 0; i < entryKind.size(); i++) begin
                if (entryKind[i] == 0) begin
                    if (resultChecker.testsRun > 0 || resultChecker.testName != "none") begin
                        resultChecker.finishTest();
                    end
                    resultChecker.startTest(entryName[i]);
                end else if (entryKind[i] == 1) begin
                    applyCycles(i);
                end else begin
                    resultChecker.pushExpected(entryTop[i]);
                end
            end
            resultChecker.finishTest();
            resultChecker.printSummary();
            if (resultChecker.errorCount == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

    initial begin
        wait (limitCycles > WATCHDOG_MARGIN);
        repeat (limitCycles) @(posedge clk);
        $display("Timeout: the run did not end within %0d clock cycles", limitCycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/botPipeVectors.txt
# T name | C rst ready start top valid count (ready 2 = random stalls)
# E count, then that many expected results in hex, in order
T basic
E 8 00000001 00000003 00000006 0000000b 00000014 00000025 00000046 00000087
C 0 1 1 00000001 0 1
C 0 1 0 00000000 0 5
C 0 1 0 00000000 1 8
C 0 1 0 00000000 0 20
T wrap
E 9 80000000 00000002 00000004 00000007 0000000c 00000015 00000026 00000047 00000088
E 9 00000109 0000020a 0000040b 0000080c 0000100d 0000200e 0000400f 80000000 00000002
C 0 1 1 80000000 0 1
C 0 1 0 00000000 0 5
C 0 1 0 00000000 1 18
C 0 1 0 00000000 0 20
T sparse
E 4 00000001 0000000b 00000025 00000046
C 0 1 1 00000001 0 1
C 0 1 0 00000000 0 5
C 0 1 0 00000000 1 1
C 0 1 0 00000000 0 2
C 0 1 0 00000000 1 1
C 0 1 0 00000000 0 1
C 0 1 0 00000000 1 2
C 0 1 0 00000000 0 20
T backpressure
E 6 00000003 00000007 0000000e 0000001b 00000034 00000065
C 0 2 1 00000003 0 1
C 0 2 0 00000000 0 5
C 0 2 0 00000000 1 6
C 0 2 0 00000000 0 20
T topchange
E 8 00000001 00000003 00000006 0000000b 80000000 00000002 00000004 00000007
C 0 1 1 00000001 0 1
C 0 1 0 00000000 0 5
C 0 1 0 00000000 1 4
C 0 1 1 80000000 1 1
C 0 1 0 00000000 1 20
C 0 1 0 00000000 0 20
T resetflight
E 2 00000002 00000005
C 0 1 1 00000001 0 1
C 0 1 0 00000000 0 5
C 0 1 0 00000000 1 3
C 1 1 0 00000000 0 3
C 0 1 1 00000002 0 1
C 0 1 0 00000000 0 5
C 0 1 0 00000000 1 2
C 0 1 0 00000000 0 20

// File: list.f
design/botPipePkg.sv
design/shiftRegister.sv
design/hyperpipe.sv
design/botValidShifter.sv
design/pipelineManager.sv
design/resultPipeline.sv
design/botPipeTop.sv
dv/botPipeChecker.sv
dv/botPipe_assert.sv
dv/botPipeTb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module botPipeTb -o botPipeSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/botPipeSim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
